/* src/core_cfg_pkg.sv */
// ================================================
// core configuration
// widths and address constants shared by the core
// ================================================

package core_cfg_pkg;

  // ================================================
  // datapath widths
  // ================================================
  // integer data width
  localparam int unsigned XLEN = 32;
  // virtual address width of pc and branch target
  localparam int unsigned VALEN = 32;

  // csr address as encoded in the instruction
  localparam int unsigned CSR_AW = 14;

  // physical register tag
  localparam int unsigned PREG_AW = 6;

  // ================================================
  // address constants
  // ================================================
  // fixed instruction size, link value and fall-through
  localparam int unsigned INST_BYTES = 4;

endpackage : core_cfg_pkg

/* src/misc_op_pkg.sv */
// ================================================
// misc pipe operations
// op encodings and payload records of the misc pipe
// ================================================

package misc_op_pkg;

  import core_cfg_pkg::*;

  // instruction class seen by the misc pipe
  typedef enum logic [1:0] {
    NONE   = 2'd0,
    BRANCH = 2'd1,
    PRIV   = 2'd2
  } inst_type_e;

  // privileged op, csr access only
  typedef enum logic [1:0] {
    PRIV_NONE = 2'd0,
    CSR_READ  = 2'd1,
    CSR_WRITE = 2'd2,
    CSR_XCHG  = 2'd3
  } priv_op_e;

  // branch condition
  typedef enum logic [2:0] {
    BR_EQ     = 3'd0,
    BR_NE     = 3'd1,
    BR_LT     = 3'd2,
    BR_GE     = 3'd3,
    BR_ALWAYS = 3'd4
  } branch_op_e;

  // ================================================
  // issued instruction
  // ================================================
  typedef struct packed {
    logic               valid;
    inst_type_e         inst_type;
    priv_op_e           priv_op;
    branch_op_e         branch_op;
    // compare signedness, link write, register target
    logic               signed_op;
    logic               br_link;
    logic               br_indirect;
    logic [VALEN-1:0]   pc;
    // predicted next pc
    logic [VALEN-1:0]   npc;
    logic [XLEN-1:0]    imm;
    logic [XLEN-1:0]    src0;
    logic [XLEN-1:0]    src1;
    logic [PREG_AW-1:0] pdest;
  } misc_exe_t;

  // ================================================
  // commit record
  // ================================================
  typedef struct packed {
    logic               valid;
    // register writeback
    logic               we;
    logic [XLEN-1:0]    wdata;
    logic [PREG_AW-1:0] pdest;
    // csr update applied when the record retires
    logic               csr_we;
    logic [CSR_AW-1:0]  csr_waddr;
    logic [XLEN-1:0]    csr_wdata;
    // branch resolution
    logic               br_taken;
    logic               br_redirect;
    logic [VALEN-1:0]   br_target;
  } misc_cmt_t;

endpackage : misc_op_pkg

/* src/misc_stage_if.sv */
// ================================================
// exec to commit link
// valid/ready handshake with the commit record
// ================================================

interface misc_stage_if;

  import misc_op_pkg::*;

  // record on offer from execute
  logic      valid;
  // commit register empty or draining this cycle
  logic      ready;
  misc_cmt_t cmt;

  // execute side
  modport exec (
    output valid,
    output cmt,
    input  ready
  );

  // commit side
  modport commit (
    input  valid,
    input  cmt,
    output ready
  );

endinterface : misc_stage_if

/* src/csr_port_if.sv */
// ================================================
// csr access port
// read from execute, write from commit
// ================================================

interface csr_port_if;

  import core_cfg_pkg::*;

  // read path, combinational
  logic [CSR_AW-1:0] raddr;
  logic [XLEN-1:0]   rdata;
  // write path, high on the retiring edge only
  logic              we;
  logic [CSR_AW-1:0] waddr;
  logic [XLEN-1:0]   wdata;

  // execute reads and watches we as write pending
  modport pipe (output raddr, input rdata, input we);

  // register file
  modport csr (input raddr, output rdata, input we, input waddr, input wdata);

  // commit stage drives the write
  modport commit (output we, output waddr, output wdata);

endinterface : csr_port_if

/* src/branch_unit.sv */
// ================================================
// branch resolution
// condition, target and redirect against npc
// ================================================

module branch_unit (
  input  logic                             signed_i,
  input  logic [core_cfg_pkg::VALEN-1:0]   pc_i,
  input  logic [core_cfg_pkg::VALEN-1:0]   npc_i,
  input  logic [core_cfg_pkg::XLEN-1:0]    imm_i,
  input  logic [core_cfg_pkg::XLEN-1:0]    src0_i,
  input  logic [core_cfg_pkg::XLEN-1:0]    src1_i,
  input  logic                             indirect_i,
  input  misc_op_pkg::branch_op_e          branch_op_i,
  input  logic                             valid_branch_i,
  output logic                             taken_o,
  output logic [core_cfg_pkg::VALEN-1:0]   target_o,
  output logic                             redirect_o
);

  import core_cfg_pkg::*;
  import misc_op_pkg::*;

  logic             eq;
  logic             lt;
  logic             cond;
  logic [VALEN-1:0] base;
  logic [VALEN-1:0] fall_thru;
  logic [VALEN-1:0] next_pc;

  // compare, lt follows the op signedness
  assign eq = (src0_i == src1_i);
  assign lt = signed_i ? ($signed(src0_i) < $signed(src1_i)) : (src0_i < src1_i);

  always_comb begin
    case (branch_op_i)
      BR_EQ:     cond = eq;
      BR_NE:     cond = ~eq;
      BR_LT:     cond = lt;
      BR_GE:     cond = ~lt;
      BR_ALWAYS: cond = 1'b1;
      default:   cond = 1'b0;
    endcase
  end

  // register based for jirl style, else pc relative
  assign base     = indirect_i ? src0_i[VALEN-1:0] : pc_i;
  assign target_o = base + imm_i[VALEN-1:0];

  assign fall_thru = pc_i + VALEN'(INST_BYTES);
  assign next_pc   = cond ? target_o : fall_thru;

  // only a live branch reports taken or mispredict
  assign taken_o    = valid_branch_i & cond;
  assign redirect_o = valid_branch_i & (next_pc != npc_i);

endmodule : branch_unit

/* src/csr_file.sv */
// ================================================
// csr file
// small csr array, async read, write on commit
// ================================================

module csr_file #(
  parameter int unsigned CSR_COUNT = 8
) (
  input logic       clk,
  input logic       rst_n,
  csr_port_if.csr   csr
);

  import core_cfg_pkg::*;

  // index taken from the low address bits
  localparam int unsigned IDX_W = $clog2(CSR_COUNT);

  logic [XLEN-1:0]  regs [CSR_COUNT];
  logic [IDX_W-1:0] ridx;
  logic [IDX_W-1:0] widx;

  assign ridx = csr.raddr[IDX_W-1:0];
  assign widx = csr.waddr[IDX_W-1:0];

  // read path feeds the exec stage in the same cycle
  assign csr.rdata = regs[ridx];

  // all csrs come up as zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < CSR_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (csr.we) begin
      regs[widx] <= csr.wdata;
    end
  end

endmodule : csr_file

/* src/misc_exec_stage.sv */
// ================================================
// misc execute stage
// branch resolve, csr read and commit record build
// ================================================

module misc_exec_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   flush_i,
  input  misc_op_pkg::misc_exe_t exe_i,
  output logic                   ready_o,
  misc_stage_if.exec             stage,
  csr_port_if.pipe               csr
);

  import core_cfg_pkg::*;
  import misc_op_pkg::*;

  logic      valid_q;
  misc_exe_t exe_q;

  logic      is_branch;
  logic      is_csr;
  logic      csr_wr;
  logic      stall;
  logic      br_taken;
  logic      br_redirect;
  logic [VALEN-1:0] br_target;
  logic [XLEN-1:0]  link_val;
  logic [XLEN-1:0]  csr_merge;

  // ================================================
  // pipeline register
  // ================================================
  // empty or moving on
  assign ready_o = ~valid_q | (stage.ready & ~stall);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= exe_i.valid;
    end
  end

  // payload only loads on a real accept
  always_ff @(posedge clk) begin
    if (ready_o && exe_i.valid) begin
      exe_q <= exe_i;
    end
  end

  // ================================================
  // decode and csr hazard
  // ================================================
  assign is_branch = (exe_q.inst_type == BRANCH);
  assign is_csr    = (exe_q.inst_type == PRIV) && (exe_q.priv_op != PRIV_NONE);
  assign csr_wr    = is_csr && (exe_q.priv_op inside {CSR_WRITE, CSR_XCHG});

  // commit can only take us while it drains, so we doubles as pending
  // hold one cycle and read again after the write lands
  assign stall = valid_q & is_csr & csr.we;

  // csr address lives in imm[13:0]
  assign csr.raddr = exe_q.imm[CSR_AW-1:0];

  // exchange keeps old bits where the mask is clear
  assign csr_merge = (csr.rdata & ~exe_q.src1) | (exe_q.src0 & exe_q.src1);

  assign link_val = XLEN'(exe_q.pc + VALEN'(INST_BYTES));

  branch_unit u_branch_unit (
    .signed_i       (exe_q.signed_op),
    .pc_i           (exe_q.pc),
    .npc_i          (exe_q.npc),
    .imm_i          (exe_q.imm),
    .src0_i         (exe_q.src0),
    .src1_i         (exe_q.src1),
    .indirect_i     (exe_q.br_indirect),
    .branch_op_i    (exe_q.branch_op),
    .valid_branch_i (valid_q & is_branch),
    .taken_o        (br_taken),
    .target_o       (br_target),
    .redirect_o     (br_redirect)
  );

  // ================================================
  // commit record
  // ================================================
  assign stage.valid = valid_q & ~stall;

  always_comb begin
    stage.cmt             = '0;
    stage.cmt.valid       = valid_q & ~stall;
    stage.cmt.pdest       = exe_q.pdest;
    stage.cmt.we          = (is_branch & exe_q.br_link) | is_csr;
    // link value for branches, old csr value for csr ops
    if (is_branch) begin
      stage.cmt.wdata = link_val;
    end else if (is_csr) begin
      stage.cmt.wdata = csr.rdata;
    end
    stage.cmt.csr_we      = csr_wr;
    stage.cmt.csr_waddr   = exe_q.imm[CSR_AW-1:0];
    stage.cmt.csr_wdata   = (exe_q.priv_op == CSR_XCHG) ? csr_merge : exe_q.src0;
    stage.cmt.br_taken    = br_taken;
    stage.cmt.br_redirect = br_redirect;
    stage.cmt.br_target   = br_target;
  end

endmodule : misc_exec_stage

/* src/misc_commit_stage.sv */
// ================================================
// misc commit stage
// holds the record until commit takes it
// ================================================

module misc_commit_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   flush_i,
  misc_stage_if.commit           stage,
  csr_port_if.commit             csr,
  output misc_op_pkg::misc_cmt_t cmt_o,
  input  logic                   cmt_ready_i
);

  import misc_op_pkg::*;

  logic      valid_q;
  misc_cmt_t rec_q;
  logic      retire;

  // empty or draining this cycle
  assign stage.ready = ~valid_q | cmt_ready_i;
  assign retire      = valid_q & cmt_ready_i;

  // ================================================
  // commit register
  // ================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (stage.ready) begin
      valid_q <= stage.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (stage.ready && stage.valid) begin
      rec_q <= stage.cmt;
    end
  end

  // valid comes from the control bit, not the stored copy
  always_comb begin
    cmt_o       = rec_q;
    cmt_o.valid = valid_q;
  end

  // ================================================
  // csr write
  // ================================================
  // only on the retiring edge, flushed records never get here
  assign csr.we    = retire & rec_q.csr_we;
  assign csr.waddr = rec_q.csr_waddr;
  assign csr.wdata = rec_q.csr_wdata;

endmodule : misc_commit_stage

/* src/misc_top.sv */
// ================================================
// misc pipe top
// ================================================

module misc_top #(
  parameter int unsigned CSR_COUNT = 8
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               flush_i,
  input  logic                               issue_valid_i,
  input  logic [1:0]                         issue_inst_type_i,
  input  logic [1:0]                         issue_priv_op_i,
  input  logic [2:0]                         issue_branch_op_i,
  input  logic                               issue_signed_i,
  input  logic                               issue_link_i,
  input  logic                               issue_indirect_i,
  input  logic [core_cfg_pkg::VALEN-1:0]     issue_pc_i,
  input  logic [core_cfg_pkg::VALEN-1:0]     issue_npc_i,
  input  logic [core_cfg_pkg::XLEN-1:0]      issue_imm_i,
  input  logic [core_cfg_pkg::XLEN-1:0]      issue_src0_i,
  input  logic [core_cfg_pkg::XLEN-1:0]      issue_src1_i,
  input  logic [core_cfg_pkg::PREG_AW-1:0]   issue_pdest_i,
  output logic                               issue_ready_o,
  output logic                               cmt_valid_o,
  output logic                               cmt_we_o,
  output logic [core_cfg_pkg::XLEN-1:0]      cmt_wdata_o,
  output logic [core_cfg_pkg::PREG_AW-1:0]   cmt_pdest_o,
  output logic                               cmt_taken_o,
  output logic                               cmt_redirect_o,
  output logic [core_cfg_pkg::VALEN-1:0]     cmt_target_o,
  input  logic                               cmt_ready_i
);

  import misc_op_pkg::*;

  misc_exe_t issue_exe;
  misc_cmt_t cmt;

  misc_stage_if stage_if ();
  csr_port_if   csr_if ();

  // pack the issue fields, op codes cast onto their enums
  assign issue_exe = '{
    valid:       issue_valid_i,
    inst_type:   inst_type_e'(issue_inst_type_i),
    priv_op:     priv_op_e'(issue_priv_op_i),
    branch_op:   branch_op_e'(issue_branch_op_i),
    signed_op:   issue_signed_i,
    br_link:     issue_link_i,
    br_indirect: issue_indirect_i,
    pc:          issue_pc_i,
    npc:         issue_npc_i,
    imm:         issue_imm_i,
    src0:        issue_src0_i,
    src1:        issue_src1_i,
    pdest:       issue_pdest_i
  };

  misc_exec_stage u_exec (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (flush_i),
    .exe_i   (issue_exe),
    .ready_o (issue_ready_o),
    .stage   (stage_if.exec),
    .csr     (csr_if.pipe)
  );

  misc_commit_stage u_commit (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (flush_i),
    .stage       (stage_if.commit),
    .csr         (csr_if.commit),
    .cmt_o       (cmt),
    .cmt_ready_i (cmt_ready_i)
  );

  csr_file #(
    .CSR_COUNT (CSR_COUNT)
  ) u_csr_file (
    .clk   (clk),
    .rst_n (rst_n),
    .csr   (csr_if.csr)
  );

  // commit record out to the plain ports
  assign cmt_valid_o    = cmt.valid;
  assign cmt_we_o       = cmt.we;
  assign cmt_wdata_o    = cmt.wdata;
  assign cmt_pdest_o    = cmt.pdest;
  assign cmt_taken_o    = cmt.br_taken;
  assign cmt_redirect_o = cmt.br_redirect;
  assign cmt_target_o   = cmt.br_target;

endmodule : misc_top

/* verification/misc_tb.sv */
// ================================================
// misc pipe testbench
// table of branch and csr ops, back-pressure, flush
// ================================================

module misc_tb;

  import core_cfg_pkg::*;
  import misc_op_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int CSR_COUNT  = 8;
  localparam int CSR_IDX_W  = $clog2(CSR_COUNT);
  localparam int NUM_ROWS   = 16;

  // one instruction and what commit should report for it
  typedef struct {
    string              name;
    inst_type_e         itype;
    priv_op_e           pop;
    branch_op_e         bop;
    logic               sgn;
    logic               link;
    logic               ind;
    logic [VALEN-1:0]   pc;
    logic [VALEN-1:0]   npc;
    logic [XLEN-1:0]    imm;
    logic [XLEN-1:0]    src0;
    logic [XLEN-1:0]    src1;
    logic [PREG_AW-1:0] pdest;
    logic               exp_we;
    logic [XLEN-1:0]    exp_wdata;
    logic               exp_taken;
    logic               exp_redir;
    logic [VALEN-1:0]   exp_target;
  } row_t;

  logic               clk = 1'b0;
  logic               rst_n;
  logic               flush_i;
  logic               issue_valid_i;
  logic [1:0]         issue_inst_type_i;
  logic [1:0]         issue_priv_op_i;
  logic [2:0]         issue_branch_op_i;
  logic               issue_signed_i;
  logic               issue_link_i;
  logic               issue_indirect_i;
  logic [VALEN-1:0]   issue_pc_i;
  logic [VALEN-1:0]   issue_npc_i;
  logic [XLEN-1:0]    issue_imm_i;
  logic [XLEN-1:0]    issue_src0_i;
  logic [XLEN-1:0]    issue_src1_i;
  logic [PREG_AW-1:0] issue_pdest_i;
  logic               issue_ready_o;
  logic               cmt_valid_o;
  logic               cmt_we_o;
  logic [XLEN-1:0]    cmt_wdata_o;
  logic [PREG_AW-1:0] cmt_pdest_o;
  logic               cmt_taken_o;
  logic               cmt_redirect_o;
  logic [VALEN-1:0]   cmt_target_o;
  logic               cmt_ready_i = 1'b0;

  row_t            tbl [NUM_ROWS];
  // accepted and not yet retired in age order
  row_t            exp_q [$];
  logic [XLEN-1:0] shadow [CSR_COUNT];
  logic            hold_back = 1'b0;
  logic [31:0]     rnd;
  int              seed = 32'h7789_6cc2;
  int              n_tests = 0;
  int              n_ok = 0;
  int              n_bad = 0;

  misc_top #(.CSR_COUNT(CSR_COUNT)) uut (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  // random commit back-pressure with ready in about three of four cycles
  always @(posedge clk) begin
    if (!rst_n || hold_back) begin
      cmt_ready_i <= 1'b0;
    end else begin
      rnd = $random(seed);
      cmt_ready_i <= rnd[1] | rnd[0];
    end
  end

  // ================================================
  // stimulus table
  // ================================================
  task automatic fill_table();
    // branches with next pc worked out by hand from pc, imm and npc
    tbl[0]  = '{"beq", BRANCH, PRIV_NONE, BR_EQ, '0, '0, '0, 32'h1000, 32'h1040,
                32'h40, 32'h5, 32'h5, 6'd1, '0, 32'h0, '1, '0, 32'h1040};
    tbl[1]  = '{"bne", BRANCH, PRIV_NONE, BR_NE, '0, '0, '0, 32'h1004, 32'h1024,
                32'h20, 32'h5, 32'h5, 6'd2, '0, 32'h0, '0, '1, 32'h1024};
    tbl[2]  = '{"blt", BRANCH, PRIV_NONE, BR_LT, '1, '0, '0, 32'h1008, 32'h100c,
                32'hfffffff0, 32'hffffffff, 32'h1, 6'd3, '0, 32'h0, '1, '1, 32'h0ff8};
    tbl[3]  = '{"bltu", BRANCH, PRIV_NONE, BR_LT, '0, '0, '0, 32'h100c, 32'h1010,
                32'h10, 32'hffffffff, 32'h1, 6'd4, '0, 32'h0, '0, '0, 32'h101c};
    tbl[4]  = '{"bge", BRANCH, PRIV_NONE, BR_GE, '1, '0, '0, 32'h1010, 32'h1110,
                32'h100, 32'h80000000, 32'h0, 6'd5, '0, 32'h0, '0, '1, 32'h1110};
    tbl[5]  = '{"bgeu", BRANCH, PRIV_NONE, BR_GE, '0, '0, '0, 32'h1014, 32'h1114,
                32'h100, 32'h80000000, 32'h0, 6'd6, '0, 32'h0, '1, '0, 32'h1114};
    // linking branches where the second is register based
    tbl[6]  = '{"bl", BRANCH, PRIV_NONE, BR_ALWAYS, '0, '1, '0, 32'h2000, 32'h2400,
                32'h400, 32'h0, 32'h0, 6'd7, '1, 32'h2004, '1, '0, 32'h2400};
    tbl[7]  = '{"jirl", BRANCH, PRIV_NONE, BR_ALWAYS, '0, '1, '1, 32'h2400, 32'h2404,
                32'h8, 32'h8000, 32'h0, 6'd8, '1, 32'h2404, '1, '1, 32'h8008};
    // csr ops return the old value in pdest
    tbl[8]  = '{"csrwr 2", PRIV, CSR_WRITE, BR_EQ, '0, '0, '0, 32'h3000, 32'h3004,
                32'h2, 32'hdeadbeef, 32'h0, 6'd9, '1, 32'h0, '0, '0, 32'h0};
    tbl[9]  = '{"csrrd 2", PRIV, CSR_READ, BR_EQ, '0, '0, '0, 32'h3004, 32'h3008,
                32'h2, 32'h0, 32'h0, 6'd10, '1, 32'hdeadbeef, '0, '0, 32'h0};
    tbl[10] = '{"csrxchg 2", PRIV, CSR_XCHG, BR_EQ, '0, '0, '0, 32'h3008, 32'h300c,
                32'h2, 32'h12345678, 32'h0000ffff, 6'd11, '1, 32'hdeadbeef, '0, '0, 32'h0};
    tbl[11] = '{"csrrd 2 merged", PRIV, CSR_READ, BR_EQ, '0, '0, '0, 32'h300c, 32'h3010,
                32'h2, 32'h0, 32'h0, 6'd12, '1, 32'hdead5678, '0, '0, 32'h0};
    tbl[12] = '{"csrwr 5", PRIV, CSR_WRITE, BR_EQ, '0, '0, '0, 32'h3010, 32'h3014,
                32'h5, 32'h0badf00d, 32'h0, 6'd13, '1, 32'h0, '0, '0, 32'h0};
    tbl[13] = '{"csrxchg 5", PRIV, CSR_XCHG, BR_EQ, '0, '0, '0, 32'h3014, 32'h3018,
                32'h5, 32'hffffffff, 32'hf0f0f0f0, 6'd14, '1, 32'h0badf00d, '0, '0, 32'h0};
    tbl[14] = '{"csrrd 5 merged", PRIV, CSR_READ, BR_EQ, '0, '0, '0, 32'h3018, 32'h301c,
                32'h5, 32'h0, 32'h0, 6'd15, '1, 32'hfbfdf0fd, '0, '0, 32'h0};
    // 0x3002 lands on index 2
    tbl[15] = '{"csrrd alias", PRIV, CSR_READ, BR_EQ, '0, '0, '0, 32'h301c, 32'h3020,
                32'h3002, 32'h0, 32'h0, 6'd16, '1, 32'hdead5678, '0, '0, 32'h0};
    for (int i = 0; i < CSR_COUNT; i++) begin
      shadow[i] = '0;
    end
  endtask

  // ================================================
  // issue side entered at a rising edge
  // ================================================
  task automatic issue_row(input row_t r, input bit track);
    issue_valid_i     <= 1'b1;
    issue_inst_type_i <= r.itype;
    issue_priv_op_i   <= r.pop;
    issue_branch_op_i <= r.bop;
    issue_signed_i    <= r.sgn;
    issue_link_i      <= r.link;
    issue_indirect_i  <= r.ind;
    issue_pc_i        <= r.pc;
    issue_npc_i       <= r.npc;
    issue_imm_i       <= r.imm;
    issue_src0_i      <= r.src0;
    issue_src1_i      <= r.src1;
    issue_pdest_i     <= r.pdest;
    // ready is settled by the falling edge
    @(negedge clk);
    while (issue_ready_o !== 1'b1) begin
      @(negedge clk);
    end
    @(posedge clk);
    if (track) begin
      exp_q.push_back(r);
    end
  endtask

  task automatic finish_test(input string name, input int bad);
    n_tests++;
    if (bad == 0) begin
      n_ok++;
      $display("test %s: ok", name);
    end else begin
      n_bad++;
      $display("test %s: %0d errors", name, bad);
    end
  endtask

  // ================================================
  // commit monitor
  // ================================================
  task automatic check_commit();
    row_t r;
    int   bad;
    int   idx;
    bad = 0;
    if (exp_q.size() == 0) begin
      $display("commit of pdest %0d arrived with nothing outstanding", cmt_pdest_o);
      finish_test("spurious commit", 1);
      return;
    end
    r = exp_q.pop_front();
    assert (cmt_we_o === r.exp_we) else begin
      $display("[FAIL] %s: cmt_we_o got %h expected %h", r.name, cmt_we_o, r.exp_we);
      bad++;
    end
    if (r.exp_we) begin
      assert (cmt_wdata_o === r.exp_wdata) else begin
        $display("[FAIL] %s: cmt_wdata_o got %h expected %h", r.name, cmt_wdata_o,
                 r.exp_wdata);
        bad++;
      end
      assert (cmt_pdest_o === r.pdest) else begin
        $display("[FAIL] %s: cmt_pdest_o got %h expected %h", r.name, cmt_pdest_o, r.pdest);
        bad++;
      end
    end
    assert (cmt_taken_o === r.exp_taken) else begin
      $display("[FAIL] %s: cmt_taken_o got %h expected %h", r.name, cmt_taken_o, r.exp_taken);
      bad++;
    end
    assert (cmt_redirect_o === r.exp_redir) else begin
      $display("[FAIL] %s: cmt_redirect_o got %h expected %h", r.name, cmt_redirect_o,
               r.exp_redir);
      bad++;
    end
    // target only means something for branches
    if (r.itype == BRANCH) begin
      assert (cmt_target_o === r.exp_target) else begin
        $display("[FAIL] %s: cmt_target_o got %h expected %h", r.name, cmt_target_o,
                 r.exp_target);
        bad++;
      end
    end
    // shadow csr array follows each retiring record
    idx = int'(r.imm[CSR_IDX_W-1:0]);
    if (r.pop == CSR_WRITE) begin
      shadow[idx] = r.src0;
    end else if (r.pop == CSR_XCHG) begin
      shadow[idx] = (shadow[idx] & ~r.src1) | (r.src0 & r.src1);
    end
    finish_test(r.name, bad);
  endtask

  // record retires at the next rising edge
  always @(negedge clk) begin
    if (rst_n && cmt_valid_o && cmt_ready_i) begin
      check_commit();
    end
  end

  task automatic wait_drained();
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    @(posedge clk);
  endtask

  // ================================================
  // flush with two csr writes in flight
  // ================================================
  task automatic run_flush();
    row_t r;
    int   bad;
    bad = 0;
    hold_back <= 1'b1;
    repeat (2) @(posedge clk);
    r = '{"flush wr 2", PRIV, CSR_WRITE, BR_EQ, '0, '0, '0, 32'h4000, 32'h4004,
          32'h2, 32'haaaa5555, 32'h0, 6'd20, '1, 32'h0, '0, '0, 32'h0};
    issue_row(r, 1'b0);
    r.imm  = 32'h5;
    r.src0 = 32'h5555aaaa;
    issue_row(r, 1'b0);
    issue_valid_i <= 1'b0;
    @(negedge clk);
    assert (cmt_valid_o === 1'b1 && issue_ready_o === 1'b0) else begin
      $display("flush setup: both stages should hold an instruction before the flush");
      bad++;
    end
    @(posedge clk);
    flush_i <= 1'b1;
    @(posedge clk);
    flush_i <= 1'b0;
    @(negedge clk);
    assert (cmt_valid_o === 1'b0) else begin
      $display("[FAIL] flush: cmt_valid_o got %h expected %h", cmt_valid_o, 1'b0);
      bad++;
    end
    assert (issue_ready_o === 1'b1) else begin
      $display("[FAIL] flush: issue_ready_o got %h expected %h", issue_ready_o, 1'b1);
      bad++;
    end
    // a surviving exec entry would reach commit one edge later
    @(negedge clk);
    assert (cmt_valid_o === 1'b0) else begin
      $display("[FAIL] flush: cmt_valid_o got %h expected %h one cycle on", cmt_valid_o,
               1'b0);
      bad++;
    end
    finish_test("flush drops two", bad);
    @(posedge clk);
    hold_back <= 1'b0;
    // reads see the pre-flush values
    r = '{"read 2 after flush", PRIV, CSR_READ, BR_EQ, '0, '0, '0, 32'h4008, 32'h400c,
          32'h2, 32'h0, 32'h0, 6'd21, '1, shadow[2], '0, '0, 32'h0};
    issue_row(r, 1'b1);
    r.name      = "read 5 after flush";
    r.imm       = 32'h5;
    r.pdest     = 6'd22;
    r.exp_wdata = shadow[5];
    issue_row(r, 1'b1);
    issue_valid_i <= 1'b0;
    wait_drained();
  endtask

  // ================================================
  // main sequence
  // ================================================
  initial begin
    int bad;
    bad = 0;
    rst_n             <= 1'b0;
    flush_i           <= 1'b0;
    issue_valid_i     <= 1'b0;
    issue_inst_type_i <= '0;
    issue_priv_op_i   <= '0;
    issue_branch_op_i <= '0;
    issue_signed_i    <= 1'b0;
    issue_link_i      <= 1'b0;
    issue_indirect_i  <= 1'b0;
    issue_pc_i        <= '0;
    issue_npc_i       <= '0;
    issue_imm_i       <= '0;
    issue_src0_i      <= '0;
    issue_src1_i      <= '0;
    issue_pdest_i     <= '0;
    fill_table();
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    assert (cmt_valid_o === 1'b0) else begin
      $display("[FAIL] reset: cmt_valid_o got %h expected %h", cmt_valid_o, 1'b0);
      bad++;
    end
    assert (issue_ready_o === 1'b1) else begin
      $display("[FAIL] reset: issue_ready_o got %h expected %h", issue_ready_o, 1'b1);
      bad++;
    end
    finish_test("reset state", bad);
    @(posedge clk);
    for (int i = 0; i < NUM_ROWS; i++) begin
      issue_row(tbl[i], 1'b1);
    end
    issue_valid_i <= 1'b0;
    wait_drained();
    run_flush();
    $display("summary: %0d tests, %0d ok, %0d with errors", n_tests, n_ok, n_bad);
    if (n_bad == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // watchdog with a generous bound per table row
  initial begin
    #(CLK_PERIOD * 40 * NUM_ROWS);
    $display("timeout: the pipe stopped retiring before the sequence finished");
    $display("tests failed");
    $finish;
  end

endmodule : misc_tb

/* project.f */
src/core_cfg_pkg.sv
src/misc_op_pkg.sv
src/misc_stage_if.sv
src/csr_port_if.sv
src/branch_unit.sv
src/csr_file.sv
src/misc_exec_stage.sv
src/misc_commit_stage.sv
src/misc_top.sv
verification/misc_tb.sv

/* Makefile */
# Verilator flow for the misc pipe
VERILATOR ?= verilator
TOP       ?= misc_tb
SRC_LIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  := all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(SRC_LIST) --top-module $(TOP)

# the run counts as passing only if the pass line shows up in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(SRC_LIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
